/* busSizerPkg.sv */
// Shared size codes, acknowledge codes and data types for the bus sizing bridge, imported by all RTL
`default_nettype none

package busSizerPkg;

    ////////////////////
    // Bus codes
    ////////////////////

    typedef logic [1:0] sizeCode_t;         // CPU SIZ encoding
    typedef logic [1:0] ackCode_t;          // Target DSACK encoding

    localparam sizeCode_t sizLword = 2'b00;
    localparam sizeCode_t sizByte  = 2'b01;
    localparam sizeCode_t sizWord  = 2'b10;
    localparam sizeCode_t sizLine  = 2'b11; // Four long words

    localparam ackCode_t ackLong = 2'b00;   // 32 bit port terminated
    localparam ackCode_t ackWord = 2'b01;   // 16 bit port terminated
    localparam ackCode_t ackWait = 2'b11;   // Idle, no termination yet

    ////////////////////
    // Data widths
    ////////////////////

    typedef logic [31:0] longWord_t;
    typedef logic [15:0] halfWord_t;
    typedef logic [1:0]  beatCount_t;       // Long word index inside a line

    // Sequencer states
    typedef enum logic [1:0] {
        seqIdle,        // Waiting for a pending CPU cycle
        seqWaitTerm,    // First or only half outstanding
        seqLowerHalf,   // Second half on a word port
        seqNextBeat     // Between long words of a line
    } seqState_t;

endpackage

`default_nettype wire

/* sizerIf.sv */
// Per-half-word event bundle from the transfer sequencer to the data path and acknowledge logic
`timescale 1ns/1ns
`default_nettype none

interface sizerIf;
    import busSizerPkg::*;

    logic       halfStrobe;     // One pulse per accepted termination
    logic       upperHalf;      // First half of a long word, word port
    logic       wordPort;       // Termination came from a 16 bit port
    logic       longDone;       // Long word complete
    beatCount_t lineBeat;       // Beat index of that long word
    logic       curWrite;       // Direction of the running transfer

    modport seq (output halfStrobe, upperHalf, wordPort, longDone, lineBeat, curWrite);

    modport sink (input halfStrobe, upperHalf, wordPort, longDone, lineBeat, curWrite);

endinterface

`default_nettype wire

/* cycleLatch.sv */
// Holds the attributes of one pending CPU cycle until the transfer sequencer takes it
`timescale 1ns/1ns
`default_nettype none

module cycleLatch
    import busSizerPkg::*;
(
    input  wire        BCLK,
    input  wire        nRESET,
    input  wire        nTsCpu,
    input  wire        rnw,
    input  sizeCode_t  siz,
    input  wire  [1:0] addr,
    input  wire        cycleTaken,
    output logic       cycleValid,
    output logic       cycleWrite,
    output sizeCode_t  cycleSize,
    output logic [1:0] cycleAddr
);

    ////////////////////
    // Pending cycle
    ////////////////////

    // A new start wins over a take in the same cycle, so a start
    // arriving while the old transfer drains is never dropped
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cycleValid <= 1'b0;
            cycleWrite <= 1'b0;
            cycleSize  <= sizLword;
            cycleAddr  <= 2'b00;
        end else begin
            if (!nTsCpu) begin
                cycleValid <= 1'b1;                 // Start sampled
                cycleWrite <= !rnw;
                cycleSize  <= siz;
                cycleAddr  <= addr;
            end else if (cycleTaken) begin
                cycleValid <= 1'b0;                 // Sequencer has it now
            end
        end
    end

endmodule

`default_nettype wire

/* transferSequencer.sv */
// FSM that issues target cycles for each CPU cycle and reacts to the port-width acknowledge
`timescale 1ns/1ns
`default_nettype none

module transferSequencer
    import busSizerPkg::*;
(
    input  wire        BCLK,
    input  wire        nRESET,
    input  wire        cycleValid,
    input  wire        cycleWrite,
    input  sizeCode_t  cycleSize,
    input  wire  [1:0] cycleAddr,
    output logic       cycleTaken,
    input  wire        fifoEmpty,
    input  longWord_t  fifoHead,
    output logic       pop,
    input  ackCode_t   dsack,
    output logic       nTsPort,
    output logic       portRnw,
    output logic [1:0] portAddr,
    output longWord_t  portDataOut,
    sizerIf.seq        evt
);

    seqState_t  state;
    sizeCode_t  curSize;
    beatCount_t beat;
    logic       longXfer;       // lword or line, may need two halves
    logic       lastBeat;
    logic       canTake;

    assign longXfer = (curSize == sizLword) || (curSize == sizLine);
    assign lastBeat = (curSize != sizLine) || (beat == 2'd3);

    // The halfStrobe cycle is also the pop cycle, fifoEmpty is stale there
    assign canTake = cycleValid && !evt.halfStrobe
                     && (cycleWrite ? !fifoEmpty : fifoEmpty);   // Reads wait for writes
    assign cycleTaken = (state == seqIdle) && canTake;

    assign pop = evt.halfStrobe && evt.longDone && evt.curWrite;

    // Lower half goes out on the upper lanes of a word port
    assign portDataOut = (state == seqLowerHalf) ? {fifoHead[15:0], fifoHead[15:0]} : fifoHead;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state          <= seqIdle;
            curSize        <= sizLword;
            beat           <= 2'd0;
            nTsPort        <= 1'b1;
            portRnw        <= 1'b1;
            portAddr       <= 2'b00;
            evt.halfStrobe <= 1'b0;
            evt.upperHalf  <= 1'b0;
            evt.wordPort   <= 1'b0;
            evt.longDone   <= 1'b0;
            evt.lineBeat   <= 2'd0;
            evt.curWrite   <= 1'b0;
        end else begin
            nTsPort        <= 1'b1;     // Start strobe lasts one cycle
            evt.halfStrobe <= 1'b0;
            evt.upperHalf  <= 1'b0;
            evt.longDone   <= 1'b0;
            case (state)
                seqIdle: begin
                    if (canTake) begin
                        curSize      <= cycleSize;
                        evt.curWrite <= cycleWrite;
                        beat         <= 2'd0;
                        nTsPort      <= 1'b0;
                        portRnw      <= !cycleWrite;
                        // Long transfers start at the upper word
                        portAddr     <= (cycleSize == sizLword || cycleSize == sizLine)
                                        ? 2'b00 : cycleAddr;
                        state        <= seqWaitTerm;
                    end
                end
                seqWaitTerm: begin
                    if (dsack != ackWait) begin
                        evt.halfStrobe <= 1'b1;
                        evt.wordPort   <= (dsack == ackWord);
                        evt.lineBeat   <= beat;
                        if (dsack == ackWord) begin
                            evt.upperHalf <= 1'b1;
                        end
                        if (dsack == ackWord && longXfer) begin
                            nTsPort  <= 1'b0;            // Second half cycle
                            portAddr <= 2'b10;
                            state    <= seqLowerHalf;
                        end else begin
                            evt.longDone <= 1'b1;
                            if (lastBeat) begin
                                portRnw <= 1'b1;
                                state   <= seqIdle;
                            end else begin
                                beat  <= beat + 2'd1;
                                state <= seqNextBeat;
                            end
                        end
                    end
                end
                seqLowerHalf: begin
                    if (dsack != ackWait) begin
                        evt.halfStrobe <= 1'b1;
                        evt.wordPort   <= 1'b1;
                        evt.longDone   <= 1'b1;
                        evt.lineBeat   <= beat;
                        if (lastBeat) begin
                            portRnw <= 1'b1;
                            state   <= seqIdle;
                        end else begin
                            beat  <= beat + 2'd1;
                            state <= seqNextBeat;
                        end
                    end
                end
                seqNextBeat: begin
                    // Writes need the next long word in the FIFO
                    if (!evt.halfStrobe && (!evt.curWrite || !fifoEmpty)) begin
                        nTsPort  <= 1'b0;
                        portAddr <= 2'b00;
                        state    <= seqWaitTerm;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* dataFifo.sv */
// Posted write FIFO of long words and the read register that joins port halves into a long word
`timescale 1ns/1ns
`default_nettype none

module dataFifo
    import busSizerPkg::*;
#(
    parameter int fifoDepth = 8
) (
    input  wire       BCLK,
    input  wire       nRESET,
    input  longWord_t cpuDataIn,
    input  wire       writeBeat,
    input  wire       pop,
    input  longWord_t portDataIn,
    output logic      fifoFull,
    output logic      fifoEmpty,
    output longWord_t fifoHead,
    output longWord_t cpuDataOut,
    sizerIf.sink      evt
);

    localparam int ptrWidth = $clog2(fifoDepth);

    longWord_t             mem [fifoDepth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [ptrWidth:0]     count;
    longWord_t             portLatch;  // Target data at the termination edge

    assign fifoFull  = (count == fifoDepth);
    assign fifoEmpty = (count == '0);
    assign fifoHead  = mem[rdPtr];

    ////////////////////
    // Write FIFO
    ////////////////////

    always_ff @(posedge BCLK) begin
        if (writeBeat) begin
            mem[wrPtr] <= cpuDataIn;    // Whole long word per beat
        end
    end

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (writeBeat) begin
                wrPtr <= wrPtr + 1'b1;  // Depth is a power of two, pointers wrap
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({writeBeat, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Read assembly
    ////////////////////

    // Events come a cycle after the termination, so keep that cycle's data
    always_ff @(posedge BCLK) begin
        portLatch <= portDataIn;
        if (evt.halfStrobe && !evt.curWrite) begin
            if (!evt.wordPort) begin
                cpuDataOut <= portLatch;                                 // Long port
            end else if (evt.upperHalf && evt.longDone) begin
                cpuDataOut <= {portLatch[31:16], portLatch[31:16]};      // Byte or word
            end else if (evt.upperHalf) begin
                cpuDataOut[31:16] <= portLatch[31:16];
            end else begin
                cpuDataOut[15:0] <= portLatch[31:16];                    // Lower half
            end
        end
    end

endmodule

`default_nettype wire

/* ackGenerator.sv */
// Drives the CPU transfer acknowledge for read long words and for accepted write beats
`timescale 1ns/1ns
`default_nettype none

module ackGenerator
    import busSizerPkg::*;
#(
    parameter int fifoDepth = 8
) (
    input  wire       BCLK,
    input  wire       nRESET,
    input  wire       nTsCpu,
    input  wire       rnw,
    input  sizeCode_t siz,
    input  wire       fifoFull,
    sizerIf.sink      evt,
    output logic      writeBeat,
    output logic      nTa
);

    logic [2:0]                  beatsLeft;  // Write beats still to accept
    logic [2:0]                  beatsNow;
    logic [$clog2(fifoDepth):0]  used;       // FIFO fill incl. the beat in flight
    logic                        popSeen;
    logic                        room;
    logic                        issueWrite;
    logic                        readAck;
    beatCount_t                  readIdx;

    assign popSeen  = evt.halfStrobe && evt.longDone && evt.curWrite;
    assign beatsNow = (!nTsCpu && !rnw) ? ((siz == sizLine) ? 3'd4 : 3'd1) : beatsLeft;
    assign room     = !fifoFull && ((used + writeBeat) < fifoDepth);
    assign issueWrite = (beatsNow != 3'd0) && room;
    // Read long words come back in line order
    assign readAck  = evt.halfStrobe && evt.longDone && !evt.curWrite
                      && (evt.lineBeat == readIdx);

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            beatsLeft <= 3'd0;
            used      <= '0;
            readIdx   <= 2'd0;
            writeBeat <= 1'b0;
            nTa       <= 1'b1;
        end else begin
            writeBeat <= issueWrite;
            nTa       <= !(issueWrite || readAck);      // One low cycle per long word
            beatsLeft <= issueWrite ? beatsNow - 3'd1 : beatsNow;
            case ({writeBeat, popSeen})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
            if (!nTsCpu) begin
                readIdx <= 2'd0;                // New cycle restarts the index
            end else if (readAck) begin
                readIdx <= readIdx + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* busSizerTop.sv */
// Top level of the dynamic bus sizing bridge, CPU local bus on one side, sized target bus on the other
`timescale 1ns/1ns
`default_nettype none

module busSizerTop
    import busSizerPkg::*;
#(
    parameter int fifoDepth = 8
) (
    input  wire        BCLK,
    input  wire        nRESET,
    // CPU side
    input  wire        nTsCpu,
    input  wire        rnw,
    input  sizeCode_t  siz,
    input  wire  [1:0] addr,
    input  longWord_t  cpuDataIn,
    output longWord_t  cpuDataOut,
    output logic       nTa,
    // Target side
    output logic       nTsPort,
    output logic       portRnw,
    output logic [1:0] portAddr,
    output longWord_t  portDataOut,
    input  longWord_t  portDataIn,
    input  ackCode_t   dsack
);

    logic       cycleValid;
    logic       cycleWrite;
    sizeCode_t  cycleSize;
    logic [1:0] cycleAddr;
    logic       cycleTaken;
    logic       fifoFull;
    logic       fifoEmpty;
    longWord_t  fifoHead;
    logic       pop;
    logic       writeBeat;

    sizerIf sizerBus ();

    cycleLatch u_cycleLatch (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .rnw(rnw), .siz(siz), .addr(addr),
        .cycleTaken(cycleTaken), .cycleValid(cycleValid), .cycleWrite(cycleWrite),
        .cycleSize(cycleSize), .cycleAddr(cycleAddr)
    );

    transferSequencer u_transferSequencer (
        .BCLK(BCLK), .nRESET(nRESET), .cycleValid(cycleValid), .cycleWrite(cycleWrite),
        .cycleSize(cycleSize), .cycleAddr(cycleAddr), .cycleTaken(cycleTaken),
        .fifoEmpty(fifoEmpty), .fifoHead(fifoHead), .pop(pop), .dsack(dsack),
        .nTsPort(nTsPort), .portRnw(portRnw), .portAddr(portAddr),
        .portDataOut(portDataOut), .evt(sizerBus.seq)
    );

    dataFifo #(.fifoDepth(fifoDepth)) u_dataFifo (
        .BCLK(BCLK), .nRESET(nRESET), .cpuDataIn(cpuDataIn), .writeBeat(writeBeat),
        .pop(pop), .portDataIn(portDataIn), .fifoFull(fifoFull), .fifoEmpty(fifoEmpty),
        .fifoHead(fifoHead), .cpuDataOut(cpuDataOut), .evt(sizerBus.sink)
    );

    ackGenerator #(.fifoDepth(fifoDepth)) u_ackGenerator (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .rnw(rnw), .siz(siz),
        .fifoFull(fifoFull), .evt(sizerBus.sink), .writeBeat(writeBeat), .nTa(nTa)
    );

endmodule

`default_nettype wire

/* tbBusSizer.sv */
// Simulation top for the bus sizing bridge with a CPU driver, a target port model, a reference model and checks
`timescale 1ns/1ns
`default_nettype none

module tbBusSizer
    import busSizerPkg::*;
();

    localparam int clkPeriod    = 40;
    localparam int numTransfers = 16;      // 15 CPU transfers plus the idle check

    typedef struct packed {
        logic       rnw;
        logic [1:0] addr;
        longWord_t  data;
        longWord_t  mask;                  // Lanes that carry write data
    } cycRec_t;

    typedef struct packed {
        logic      rd;
        longWord_t data;
    } ackRec_t;

    logic       BCLK;
    logic       nRESET;
    logic       nTsCpu;
    logic       rnw;
    sizeCode_t  siz;
    logic [1:0] addr;
    longWord_t  cpuDataIn;
    longWord_t  cpuDataOut;
    logic       nTa;
    logic       nTsPort;
    logic       portRnw;
    logic [1:0] portAddr;
    longWord_t  portDataOut;
    longWord_t  portDataIn;
    ackCode_t   dsack;

    longWord_t tgtMem [16];                // Target memory
    longWord_t refMem [16];                // Shadow copy kept by the reference
    longWord_t beatData [4];               // CPU write beats of the current transfer
    cycRec_t   expCycQ [$];
    cycRec_t   logQ [$];                   // Target cycles as seen on the port
    ackRec_t   ackQ [$];
    int        idxQ [$];                   // Memory index per expected target cycle
    logic      widePort;                   // Width the target answers with
    int        cyclesSeen;
    int        cyclesPushed;
    int        lastFirst;
    int        valueErrors;
    int        otherErrors;

    busSizerTop u_busSizerTop (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .rnw(rnw), .siz(siz), .addr(addr),
        .cpuDataIn(cpuDataIn), .cpuDataOut(cpuDataOut), .nTa(nTa), .nTsPort(nTsPort),
        .portRnw(portRnw), .portAddr(portAddr), .portDataOut(portDataOut),
        .portDataIn(portDataIn), .dsack(dsack)
    );

    initial begin
        BCLK = 1'b0;
        forever #(clkPeriod / 2) BCLK = ~BCLK;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic void pushCycle(input logic cycRnw, input logic [1:0] a,
                                      input longWord_t d, input longWord_t m, input int idx);
        cycRec_t rec;
        rec.rnw  = cycRnw;
        rec.addr = a;
        rec.data = d;
        rec.mask = m;
        expCycQ.push_back(rec);
        idxQ.push_back(idx);
        cyclesPushed++;
    endfunction

    // Expected target cycles and CPU beats; short cycles assume a word port
    function automatic void expectTransfer(input logic write, input sizeCode_t size,
                                           input logic [1:0] a, input int base);
        int        nLong;
        int        idx;
        int        i;
        logic      isLong;
        halfWord_t h;
        ackRec_t   ack;
        nLong  = (size == sizLine) ? 4 : 1;
        isLong = (size == sizLword) || (size == sizLine);
        for (i = 0; i < nLong; i++) begin
            idx      = (base + i) % 16;
            ack.rd   = !write;
            ack.data = '0;
            if (!isLong) begin
                if (write) begin                              // Half lands at addr[1]
                    if (a[1]) refMem[idx][15:0] = beatData[0][31:16];
                    else      refMem[idx][31:16] = beatData[0][31:16];
                    pushCycle(1'b0, a, beatData[0], 32'hFFFF_0000, idx);
                end else begin
                    h        = a[1] ? refMem[idx][15:0] : refMem[idx][31:16];
                    ack.data = {h, h};                        // Copied to both halves
                    pushCycle(1'b1, a, '0, '0, idx);
                end
            end else if (widePort) begin
                if (write) begin
                    refMem[idx] = beatData[i];
                    pushCycle(1'b0, 2'b00, beatData[i], 32'hFFFF_FFFF, idx);
                end else begin
                    ack.data = refMem[idx];
                    pushCycle(1'b1, 2'b00, '0, '0, idx);
                end
            end else begin
                // Upper half at 0, lower half at 2, both on the upper lanes
                if (write) refMem[idx] = beatData[i];
                ack.data = write ? '0 : refMem[idx];
                pushCycle(!write, 2'b00, {beatData[i][31:16], 16'h0},
                          write ? 32'hFFFF_0000 : '0, idx);
                pushCycle(!write, 2'b10, {beatData[i][15:0], 16'h0},
                          write ? 32'hFFFF_0000 : '0, idx);
            end
            ackQ.push_back(ack);
        end
    endfunction

    ////////////////////
    // Target port
    ////////////////////

    initial begin : targetModel
        cycRec_t   rec;
        int        idx;
        int        waitCycles;
        halfWord_t h;
        forever begin
            @(negedge BCLK);
            dsack = ackWait;                                  // Termination lasts one cycle
            if (nRESET && nTsPort === 1'b0) begin
                rec.rnw  = portRnw;
                rec.addr = portAddr;
                rec.data = portDataOut;
                rec.mask = '0;
                logQ.push_back(rec);
                cyclesSeen++;
                idx        = (idxQ.size() != 0) ? idxQ.pop_front() : 0;
                waitCycles = $urandom_range(3, 0);
                repeat (waitCycles) @(negedge BCLK);
                if (widePort) begin
                    if (rec.rnw) portDataIn = tgtMem[idx];
                    else         tgtMem[idx] = rec.data;
                    dsack = ackLong;
                end else begin
                    h = rec.addr[1] ? tgtMem[idx][15:0] : tgtMem[idx][31:16];
                    if (rec.rnw)          portDataIn = {h, h};
                    else if (rec.addr[1]) tgtMem[idx][15:0] = rec.data[31:16];
                    else                  tgtMem[idx][31:16] = rec.data[31:16];
                    dsack = ackWord;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic flagMismatch(input string name, input longWord_t got, input longWord_t exp);
        valueErrors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    initial begin : compareProc
        cycRec_t got;
        cycRec_t exp;
        ackRec_t ack;
        forever begin
            @(negedge BCLK);
            while (logQ.size() != 0) begin
                got = logQ.pop_front();
                if (expCycQ.size() == 0) begin
                    otherErrors++;
                    $display("Error at %0t ns: target cycle without a CPU start", $time);
                end else begin
                    exp = expCycQ.pop_front();
                    if (got.rnw !== exp.rnw) flagMismatch("portRnw", got.rnw, exp.rnw);
                    if (got.addr !== exp.addr) flagMismatch("portAddr", got.addr, exp.addr);
                    if ((got.data & exp.mask) !== (exp.data & exp.mask))
                        flagMismatch("portDataOut", got.data & exp.mask, exp.data & exp.mask);
                end
            end
            if (nRESET && nTa === 1'b0) begin
                if (ackQ.size() == 0) begin
                    otherErrors++;
                    $display("Error at %0t ns: nTa pulse with no CPU beat outstanding", $time);
                end else begin
                    ack = ackQ.pop_front();
                    if (ack.rd && cpuDataOut !== ack.data)
                        flagMismatch("cpuDataOut", cpuDataOut, ack.data);
                end
            end
        end
    end

    initial begin : watchdog
        #(clkPeriod * (8 + 200 * numTransfers));
        $display("Timeout: transfers stopped completing, %0d value errors, %0d other errors",
                 valueErrors, otherErrors);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // CPU driver
    ////////////////////

    task automatic runTransfer(input logic write, input sizeCode_t size, input logic [1:0] a,
                               input logic isWide, input int base);
        int nLong;
        int i;
        nLong = (size == sizLine) ? 4 : 1;
        for (i = 0; i < 4; i++) beatData[i] = $urandom();
        while (cyclesSeen <= lastFirst) @(negedge BCLK);     // Latch holds only one pending
        widePort  = isWide;
        lastFirst = cyclesPushed;
        expectTransfer(write, size, a, base);
        rnw       = !write;
        siz       = size;
        addr      = a;
        cpuDataIn = beatData[0];
        nTsCpu    = 1'b0;
        @(negedge BCLK);
        nTsCpu = 1'b1;
        for (i = 0; i < nLong; i++) begin
            cpuDataIn = beatData[i];                          // Held until its nTa
            while (nTa !== 1'b0) @(negedge BCLK);
            @(negedge BCLK);
        end
    endtask

    task automatic drain();
        while (expCycQ.size() != 0 || ackQ.size() != 0) @(negedge BCLK);
        repeat (3) @(negedge BCLK);
    endtask

    initial begin
        void'($urandom(43050));
        nRESET       = 1'b0;
        nTsCpu       = 1'b1;
        rnw          = 1'b1;
        siz          = sizLword;
        addr         = 2'b00;
        cpuDataIn    = '0;
        portDataIn   = '0;
        dsack        = ackWait;
        widePort     = 1'b1;
        cyclesSeen   = 0;
        cyclesPushed = 0;
        lastFirst    = -1;
        valueErrors  = 0;
        otherErrors  = 0;
        for (int i = 0; i < 16; i++) begin
            tgtMem[i] = $urandom();
            refMem[i] = tgtMem[i];
        end
        repeat (8) @(negedge BCLK);
        nRESET = 1'b1;
        @(negedge BCLK);
        if (nTa !== 1'b1) flagMismatch("nTa", nTa, 1);
        if (nTsPort !== 1'b1) flagMismatch("nTsPort", nTsPort, 1);
        repeat (20) @(negedge BCLK);                          // Port must stay quiet without a CPU start
        runTransfer(1'b0, sizLword, 2'b00, 1'b1, 3);
        drain();
        runTransfer(1'b0, sizLword, 2'b00, 1'b0, 5);
        drain();
        runTransfer(1'b0, sizLine,  2'b00, 1'b1, 8);
        drain();
        runTransfer(1'b0, sizLine,  2'b00, 1'b0, 14);   // Wraps the memory
        drain();
        runTransfer(1'b1, sizLword, 2'b00, 1'b1, 1);
        drain();
        runTransfer(1'b1, sizLine,  2'b00, 1'b0, 4);
        drain();
        runTransfer(1'b1, sizLine,  2'b00, 1'b1, 0);
        drain();
        runTransfer(1'b1, sizLword, 2'b00, 1'b0, 9);
        drain();
        // Short cycles on a word port
        runTransfer(1'b0, sizWord,  2'b10, 1'b0, 6);
        drain();
        runTransfer(1'b0, sizByte,  2'b01, 1'b0, 7);
        drain();
        runTransfer(1'b1, sizWord,  2'b00, 1'b0, 10);
        drain();
        runTransfer(1'b0, sizWord,  2'b00, 1'b0, 10);
        drain();
        // Posted writes, then a read of the line just written
        runTransfer(1'b1, sizLword, 2'b00, 1'b0, 14);
        runTransfer(1'b1, sizLine,  2'b00, 1'b0, 0);
        runTransfer(1'b0, sizLword, 2'b00, 1'b0, 2);
        drain();
        repeat (5) @(negedge BCLK);
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
busSizerPkg.sv
sizerIf.sv
cycleLatch.sv
transferSequencer.sv
dataFifo.sv
ackGenerator.sv
busSizerTop.sv
tbBusSizer.sv

/* Makefile */
# Verilator simulation of the bus sizing bridge

VERILATOR ?= verilator
TOP       ?= tbBusSizer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
